// ==== arithmeticEncoder.f ====
+incdir+include
design/codecPkg.sv
design/symbolModel.sv
design/intervalDivider.sv
design/encoderControl.sv
design/bitPacker.sv
design/arithmeticEncoder.sv
sim/tbArithmeticEncoder.sv

// ==== run.sh ====
#!/bin/sh
# build and run the arithmetic encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tbArithmeticEncoder -f arithmeticEncoder.f \
    -o simArithmeticEncoder
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi
./obj_dir/simArithmeticEncoder > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1

// ==== include/encoderRefModel.svh ====
// behavioral reference encoder: model rule, interval narrowing, rescaling and word packing
`ifndef ENCODER_REF_MODEL_SVH
`define ENCODER_REF_MODEL_SVH

typedef bit [31:0] refWords_t[$];

function automatic void packBit(ref bit [31:0] word, ref int count, ref refWords_t words,
                                input bit value);
    word[count] = value;
    count++;
    if (count == 32) begin
        words.push_back(word);  // full word, valid bytes 4
        word = '0;
        count = 0;
    end
endfunction

// message must end with EOF, lastBytes is the valid byte count of the final word
function automatic refWords_t encodeMessage(input int precision, input int message[$],
                                            output int lastBytes);
    refWords_t words;
    bit [31:0] word;
    longint whole, half, quarter, a, b, w, fBegin, fEnd;
    int s, count;
    bit v;
    whole = 64'd1 << (precision - 1);
    half = whole >> 1;
    quarter = whole >> 2;
    a = 0;
    b = whole;
    w = whole;
    s = 0;
    count = 0;
    word = '0;
    foreach (message[i]) begin
        fBegin = (message[i] > codecPkg::heavySymbol) ? message[i] + 130814 : message[i];
        fEnd = (message[i] == codecPkg::heavySymbol) ? codecPkg::heavyFreqEnd : fBegin + 1;
        b = a + w * fEnd / codecPkg::totalFreq;
        a = a + w * fBegin / codecPkg::totalFreq;
        while (1) begin
            if (b < half || a > half) begin
                v = !(b < half);
                packBit(word, count, words, v);
                repeat (s) packBit(word, count, words, !v);
                s = 0;
                a = v ? (a - half) << 1 : a << 1;
                b = v ? (b - half) << 1 : b << 1;
            end else if (a > quarter && b < 3 * quarter) begin
                a = (a - quarter) << 1;
                b = (b - quarter) << 1;
                s++;
            end else break;
        end
        w = b - a;
        if (message[i] == codecPkg::eofSymbol) begin
            s++;
            v = a > quarter;
            packBit(word, count, words, v);
            repeat (s) packBit(word, count, words, !v);
        end
    end
    lastBytes = (count != 0) ? (count + 7) / 8 : 4;
    if (count != 0) words.push_back(word);
    return words;
endfunction

`endif

// ==== sim/tbArithmeticEncoder.sv ====
// testbench for the arithmetic encoder: clock, reset, host strobe tasks, directed tests, timeout
`include "encoderRefModel.svh"

module tbArithmeticEncoder;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int precision = 20;

    logic clk;
    logic rstn;
    logic start;
    codecPkg::symbol_t symbolIn;
    logic symbolProvided;
    logic readAck;
    logic idle;
    logic symbolRequested;
    logic resultReady;
    logic [31:0] out;
    logic [2:0] validBytes;

    int cycles = 0;
    int cycleLimit = 2000;              // raised by every message and every host delay
    bit sendDone;
    int message[$];

    arithmeticEncoder #(.precision(precision)) uut (
        .clk(clk), .rstn(rstn), .start(start), .symbolIn(symbolIn),
        .symbolProvided(symbolProvided), .readAck(readAck), .idle(idle),
        .symbolRequested(symbolRequested), .resultReady(resultReady), .out(out),
        .validBytes(validBytes)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: the encoder did not finish within %0d cycles", cycleLimit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic stopRun();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic hostDelay(input bit useDelays);
        int cyclesToWait;
        cyclesToWait = useDelays ? $urandom_range(0, 10) : 0;
        cycleLimit += cyclesToWait;
        repeat (cyclesToWait) @(posedge clk);
    endtask

    task automatic sendSymbols(input int msg[$], input bit useDelays);
        do @(negedge clk); while (!idle);
        @(posedge clk);
        symbolIn <= codecPkg::symbol_t'(msg[0]);  // first symbol goes with start
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 1; i < msg.size(); i++) begin
            do @(negedge clk); while (!symbolRequested);
            hostDelay(useDelays);
            @(posedge clk);
            symbolIn <= codecPkg::symbol_t'(msg[i]);
            symbolProvided <= 1'b1;
            do @(negedge clk); while (symbolRequested);
            @(posedge clk);
            symbolProvided <= 1'b0;
        end
        sendDone = 1'b1;
    endtask

    task automatic collectWords(output refWords_t words, output int byteCounts[$],
                                input bit useDelays);
        bit finished;
        words = {};
        byteCounts = {};
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (resultReady) begin
                words.push_back(out);
                byteCounts.push_back(int'(validBytes));
                hostDelay(useDelays);
                @(posedge clk);
                readAck <= 1'b1;
                do @(negedge clk); while (resultReady);
                @(posedge clk);
                readAck <= 1'b0;
            end else begin
                finished = sendDone && idle;    // idle rises only after the last word is read
            end
        end
    endtask

    task automatic runMessage(input string name, input int msg[$], input bit useDelays,
                              output refWords_t words);
        int byteCounts[$];
        refWords_t expWords;
        int expLast;
        cycleLimit += 250 * msg.size();
        sendDone = 1'b0;
        fork
            sendSymbols(msg, useDelays);
            collectWords(words, byteCounts, useDelays);
        join
        expWords = encodeMessage(precision, msg, expLast);
        assert (words.size() == expWords.size()) else begin
            $display("ERROR: %s word count expected %h actual %h", name, expWords.size(),
                     words.size());
            stopRun();
        end
        foreach (expWords[i]) begin
            assert (words[i] == expWords[i]) else begin
                $display("ERROR: %s out word %0d expected %h actual %h", name, i,
                         expWords[i], words[i]);
                stopRun();
            end
            assert (byteCounts[i] == ((i == expWords.size() - 1) ? expLast : 4)) else begin
                $display("ERROR: %s validBytes word %0d expected %h actual %h", name, i,
                         (i == expWords.size() - 1) ? expLast : 4, byteCounts[i]);
                stopRun();
            end
        end
    endtask

    task automatic checkResetState();
        @(negedge clk);
        assert (idle && !resultReady && !symbolRequested && out == 32'h0) else begin
            $display("ERROR: reset state idle %h resultReady %h symbolRequested %h out %h",
                     idle, resultReady, symbolRequested, out);
            stopRun();
        end
    endtask

    task automatic eofOnlyMessage();
        int msg[$];
        refWords_t words;
        msg.push_back(codecPkg::eofSymbol);
        runMessage("eof only", msg, 1'b0, words);   // returns only once idle is back
    endtask

    task automatic heavySymbolRun();
        int msg[$];
        refWords_t words;
        repeat (12) msg.push_back(codecPkg::heavySymbol);
        msg.push_back(codecPkg::eofSymbol);
        runMessage("heavy run", msg, 1'b0, words);
        assert (words.size() == 1) else begin
            $display("a run of the heavy symbol did not fit in one partial word");
            stopRun();
        end
    endtask

    task automatic randomMixedMessage();
        refWords_t words;
        message = {};
        repeat (39) message.push_back(($urandom_range(0, 3) == 0) ?
                                      $urandom_range(0, 255) : codecPkg::heavySymbol);
        message.push_back(codecPkg::eofSymbol);
        runMessage("random", message, 1'b0, words);
        assert (words.size() > 1) else begin
            $display("the random message did not span several words");
            stopRun();
        end
    endtask

    task automatic delayedHandshakes();
        refWords_t words;
        runMessage("back pressure", message, 1'b1, words);
    endtask

    task automatic backToBackMessages();
        int first[$];
        refWords_t words;
        repeat (9) first.push_back($urandom_range(0, 255));    // mostly rare, long interval tail
        first.push_back(codecPkg::eofSymbol);
        runMessage("first of two", first, 1'b0, words);
        runMessage("second of two", '{97, 97, 3, 97, 200, 97, 97, 256}, 1'b0, words);
    endtask

    initial begin
        void'($urandom(32'he224df29));
        rstn = 1'b0;
        start = 1'b0;
        symbolIn = '0;
        symbolProvided = 1'b0;
        readAck = 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        checkResetState();
        eofOnlyMessage();
        heavySymbolRun();
        randomMixedMessage();
        delayedHandshakes();
        backToBackMessages();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== design/arithmeticEncoder.sv ====
// arithmetic encoder top level: control FSM, symbol model, divider and bit packer
module arithmeticEncoder #(
    parameter int precision = 20
) (
    input logic clk,
    input logic rstn,
    input logic start,
    input codecPkg::symbol_t symbolIn,
    input logic symbolProvided,
    input logic readAck,
    output logic idle,
    output logic symbolRequested,
    output logic resultReady,
    output logic [31:0] out,
    output logic [2:0] validBytes
);
    import codecPkg::*;

    symbol_t symbol;
    freq_t freqBegin;
    freq_t freqEnd;
    logic divStart;
    logic [2*precision-3:0] dividend;
    logic divDone;
    logic [precision-1:0] quotient;
    logic bitValid;
    logic bitValue;
    logic flush;
    logic bitReady;

    encoderControl #(.precision(precision)) control (
        .clk(clk), .rstn(rstn), .start(start), .symbolIn(symbolIn),
        .symbolProvided(symbolProvided), .freqBegin(freqBegin), .freqEnd(freqEnd),
        .divDone(divDone), .quotient(quotient), .bitReady(bitReady), .symbol(symbol),
        .divStart(divStart), .dividend(dividend), .symbolRequested(symbolRequested),
        .bitValid(bitValid), .bitValue(bitValue), .flush(flush), .idle(idle)
    );

    symbolModel model (.symbol(symbol), .freqBegin(freqBegin), .freqEnd(freqEnd));

    intervalDivider #(.precision(precision)) divider (
        .clk(clk), .rstn(rstn), .divStart(divStart), .dividend(dividend),
        .divDone(divDone), .quotient(quotient)
    );

    bitPacker packer (
        .clk(clk), .rstn(rstn), .bitValid(bitValid), .bitValue(bitValue), .flush(flush),
        .readAck(readAck), .bitReady(bitReady), .resultReady(resultReady), .out(out),
        .validBytes(validBytes)
    );

endmodule

// ==== design/bitPacker.sv ====
// bit packer: emitted bits into 32-bit words, valid byte count and read acknowledge
module bitPacker (
    input logic clk,
    input logic rstn,
    input logic bitValid,
    input logic bitValue,
    input logic flush,
    input logic readAck,
    output logic bitReady,
    output logic resultReady,
    output logic [31:0] out,
    output logic [2:0] validBytes
);

    logic [4:0] bitCount;               // next free bit position, LSB first
    logic waitRelease;                  // acknowledge seen, waiting for it to drop
    logic [5:0] roundedCount;

    assign bitReady = !resultReady && !waitRelease;
    assign roundedCount = {1'b0, bitCount} + 6'd7;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out <= '0;
            bitCount <= '0;
            resultReady <= 1'b0;
            waitRelease <= 1'b0;
            validBytes <= '0;
        end else if (resultReady) begin
            if (readAck) begin
                resultReady <= 1'b0;
                waitRelease <= 1'b1;
                out <= '0;
                bitCount <= '0;
            end
        end else if (waitRelease) begin
            if (!readAck) waitRelease <= 1'b0;
        end else if (bitValid) begin
            out[bitCount] <= bitValue;
            bitCount <= bitCount + 5'd1;
            if (bitCount == 5'd31) begin
                resultReady <= 1'b1;    // full word
                validBytes <= 3'd4;
            end
        end else if (flush && bitCount != 0) begin
            resultReady <= 1'b1;        // partial word, bytes rounded up
            validBytes <= roundedCount[5:3];
        end
    end

endmodule

// ==== design/encoderControl.sv ====
// encoder FSM: interval narrowing, rescaling, pending bits, symbol requests and final flush
module encoderControl #(
    parameter int precision = 20
) (
    input logic clk,
    input logic rstn,
    input logic start,
    input codecPkg::symbol_t symbolIn,
    input logic symbolProvided,
    input codecPkg::freq_t freqBegin,
    input codecPkg::freq_t freqEnd,
    input logic divDone,
    input logic [precision-1:0] quotient,
    input logic bitReady,
    output codecPkg::symbol_t symbol,
    output logic divStart,
    output logic [2*precision-3:0] dividend,
    output logic symbolRequested,
    output logic bitValid,
    output logic bitValue,
    output logic flush,
    output logic idle
);
    import codecPkg::*;

    localparam int productWidth = 2*precision - 2;
    localparam logic [precision-1:0] whole = 1 << (precision - 1);
    localparam logic [precision-1:0] half = 1 << (precision - 2);
    localparam logic [precision-1:0] quarter = 1 << (precision - 3);
    localparam logic [precision-1:0] threeQuarters = 3 * quarter;

    encState_t state;
    logic [precision-1:0] a;            // interval low
    logic [precision-1:0] b;            // interval high
    logic [precision-1:0] w;            // interval width for the current symbol
    logic [6:0] s;                      // pending bits from middle expansions
    logic [productWidth-1:0] lowProduct;
    logic pendingValue;
    logic finalPhase;                   // EOF tail is being emitted
    logic lowerHalf;
    logic upperHalf;
    logic middle;
    logic finalOne;

    assign lowerHalf = b < half;
    assign upperHalf = a > half;
    assign middle = (a > quarter) && (b < threeQuarters);
    assign finalOne = a > quarter;
    assign idle = state == stIdle;

    always_comb begin
        bitValid = 1'b0;
        bitValue = 1'b0;
        flush = 1'b0;
        case (state)
            stRescale: begin
                bitValid = lowerHalf || upperHalf;
                bitValue = !lowerHalf;
            end
            stPending: begin
                bitValid = 1'b1;
                bitValue = pendingValue;
            end
            stFinalBit: begin
                bitValid = 1'b1;
                bitValue = finalOne;
            end
            stFlush: flush = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= stIdle;
            divStart <= 1'b0;
            symbolRequested <= 1'b0;
            s <= '0;
            finalPhase <= 1'b0;
        end else begin
            divStart <= 1'b0;
            case (state)
                stIdle: begin
                    a <= '0;
                    b <= whole;
                    w <= whole;
                    s <= '0;
                    finalPhase <= 1'b0;
                    if (start) begin
                        symbol <= symbolIn;
                        state <= stMultiply;
                    end
                end
                stMultiply: begin
                    dividend <= productWidth'(w) * productWidth'(freqEnd);
                    lowProduct <= productWidth'(w) * productWidth'(freqBegin);
                    divStart <= 1'b1;
                    state <= stDivHigh;
                end
                stDivHigh: if (divDone) begin
                    b <= a + quotient;          // old a, start is updated next
                    dividend <= lowProduct;
                    divStart <= 1'b1;
                    state <= stDivLow;
                end
                stDivLow: if (divDone) begin
                    a <= a + quotient;
                    state <= stRescale;
                end
                stRescale: begin
                    if (lowerHalf || upperHalf) begin
                        if (bitReady) begin
                            pendingValue <= lowerHalf;  // pending bits are the complement
                            if (lowerHalf) begin
                                a <= a << 1;
                                b <= b << 1;
                            end else begin
                                a <= (a - half) << 1;
                                b <= (b - half) << 1;
                            end
                            if (s != 0) state <= stPending;
                        end
                    end else if (middle) begin
                        a <= (a - quarter) << 1;
                        b <= (b - quarter) << 1;
                        s <= s + 7'd1;
                    end else if (symbol == symbol_t'(eofSymbol)) begin
                        s <= s + 7'd1;
                        state <= stFinalBit;
                    end else begin
                        symbolRequested <= 1'b1;
                        state <= stRequest;
                    end
                end
                stPending: if (bitReady) begin
                    s <= s - 7'd1;
                    if (s == 7'd1) state <= finalPhase ? stFlush : stRescale;
                end
                stRequest: if (symbolProvided) begin
                    symbol <= symbolIn;
                    symbolRequested <= 1'b0;
                    state <= stRelease;
                end
                stRelease: if (!symbolProvided) begin
                    w <= b - a;
                    state <= stMultiply;
                end
                stFinalBit: if (bitReady) begin
                    pendingValue <= !finalOne;
                    finalPhase <= 1'b1;
                    state <= stPending;
                end
                stFlush: if (bitReady) state <= stDrain;
                stDrain: if (bitReady) state <= stIdle;   // host has read the last word
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// ==== design/intervalDivider.sv ====
// restoring shift-subtract divider: scaled product divided by the total frequency count
module intervalDivider #(
    parameter int precision = 20
) (
    input logic clk,
    input logic rstn,
    input logic divStart,
    input logic [2*precision-3:0] dividend,
    output logic divDone,
    output logic [precision-1:0] quotient
);
    import codecPkg::*;

    localparam int steps = 2*precision - 2;    // one quotient bit per dividend bit
    localparam int countWidth = $clog2(steps + 1);
    localparam int trialWidth = freqWidth + 1;
    localparam logic [trialWidth-1:0] divisor = trialWidth'(totalFreq);

    logic [countWidth-1:0] count;
    logic [steps-1:0] work;             // dividend bits leave at the top, quotient bits enter below
    logic [freqWidth-1:0] remainder;
    logic [trialWidth-1:0] trial;
    logic fits;

    assign trial = {remainder, work[steps-1]};
    assign fits = trial >= divisor;
    assign quotient = work[precision-1:0];     // upper quotient bits are always zero

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
            divDone <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                count <= countWidth'(steps);
            end else if (count != 0) begin
                count <= count - 1'b1;
                divDone <= (count == 1);     // last step, quotient complete
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin
            work <= dividend;
            remainder <= '0;
        end else if (count != 0) begin
            work <= {work[steps-2:0], fits};
            remainder <= fits ? freqWidth'(trial - divisor) : trial[freqWidth-1:0];
        end
    end

endmodule

// ==== design/symbolModel.sv ====
// fixed probability model: cumulative frequency range of one symbol
module symbolModel (
    input codecPkg::symbol_t symbol,
    output codecPkg::freq_t freqBegin,
    output codecPkg::freq_t freqEnd
);
    import codecPkg::*;

    // symbols above the heavy one sit behind its wide range
    localparam freq_t rareOffset = freq_t'(heavyFreqEnd - heavySymbol - 1);

    logic isRare;
    logic isHeavy;
    freq_t offset;

    assign isRare = symbol > symbol_t'(heavySymbol);
    assign isHeavy = symbol == symbol_t'(heavySymbol);
    assign offset = isRare ? rareOffset : '0;

    assign freqBegin = freq_t'(symbol) + offset;
    assign freqEnd = isHeavy ? freq_t'(heavyFreqEnd) : freqBegin + freq_t'(1);

endmodule

// ==== design/codecPkg.sv ====
// codec package: probability model constants, symbol and frequency types, encoder FSM states
package codecPkg;

    localparam int numSymbols = 257;        // 256 byte values plus end of message
    localparam int eofSymbol = 256;
    localparam int symbolWidth = $clog2(numSymbols);
    localparam int heavySymbol = 97;        // the one highly probable symbol
    localparam int heavyFreqEnd = 130912;
    localparam int totalFreq = 131071;
    localparam int freqWidth = 17;

    typedef logic [symbolWidth-1:0] symbol_t;
    typedef logic [freqWidth-1:0] freq_t;

    typedef enum logic [3:0] {
        stIdle = 4'd0,
        stMultiply = 4'd1,      // both products of width and cumulative frequency
        stDivHigh = 4'd2,       // new interval end
        stDivLow = 4'd3,        // new interval start
        stRescale = 4'd4,
        stPending = 4'd5,       // complement bits left over from middle expansions
        stRequest = 4'd6,
        stRelease = 4'd7,
        stFinalBit = 4'd8,
        stFlush = 4'd9,
        stDrain = 4'd10         // last word still held by the packer
    } encState_t;

endpackage
